// File: design/snake_pkg.sv
package snake_pkg;

    // body and grid sizes
    localparam int BODY_LEN = 4;
    localparam int GRID_X = 16;
    localparam int GRID_Y = 3;
    localparam int DIGITS = 8;
    localparam int SEGS_PER_DIGIT = 7;

    // apb register map
    localparam logic [3:0] ADDR_CTRL = 4'd0;
    localparam logic [3:0] ADDR_STATUS = 4'd4;

    // step counter saturates here
    localparam logic [7:0] STEP_MAX = 8'd255;

    // bit position of each segment inside one digit, a at the lsb
    localparam int SEG_A = 0;
    localparam int SEG_B = 1;
    localparam int SEG_C = 2;
    localparam int SEG_D = 3;
    localparam int SEG_E = 4;
    localparam int SEG_F = 5;
    localparam int SEG_G = 6;

    // opposite headings differ only in bit 0
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_RIGHT = 2'd3
    } heading_t;

    typedef struct packed {
        logic [3:0] x;
        logic [1:0] y;
    } node_t;

    localparam node_t START_NODE = '{x: 4'd0, y: 2'd0};

    // level 0 is a, 1 is g, 2 is d
    typedef struct packed {
        logic       spare;
        logic [2:0] digit;
        logic [1:0] level;
    } horiz_seg_t;

    // even column is the left side of digit column/2, odd the right side
    typedef struct packed {
        logic       spare;
        logic [3:0] column;
        logic       half;
    } vert_seg_t;

    typedef union packed {
        horiz_seg_t h;
        vert_seg_t  v;
    } seg_pos_u;

    // vertical picks the view of pos
    typedef struct packed {
        logic     valid;
        logic     vertical;
        seg_pos_u pos;
    } edge_t;

    typedef struct packed {
        logic  valid;
        edge_t new_edge;
    } step_t;

    typedef struct packed {
        logic wall;
        logic self;
    } hit_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// File: design/apb_ctrl_regs.sv
`timescale 1ns/1ps

module apb_ctrl_regs (
    input  logic                clock_10hz,
    input  logic                reset,
    input  snake_pkg::apb_req_t apb_req,
    output snake_pkg::apb_rsp_t apb_rsp,
    input  logic                step,
    input  snake_pkg::hit_t     hit,
    output logic                run,
    output snake_pkg::heading_t dir_req,
    output logic                alive
);

    import snake_pkg::*;

    logic       access;
    logic       wr_ctrl;
    logic       dead;
    logic [7:0] step_count;

    // access phase, no wait states
    assign access = apb_req.psel & apb_req.penable;
    assign wr_ctrl = access & apb_req.pwrite & (apb_req.paddr == ADDR_CTRL);

    // control register
    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            run <= 1'b0;
            dir_req <= DIR_RIGHT;
        end else if (wr_ctrl) begin
            run <= apb_req.pwdata[0];
            dir_req <= heading_t'(apb_req.pwdata[2:1]);
        end
    end

    // dead is sticky until reset
    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            dead <= 1'b0;
        end else if (hit.wall || hit.self) begin
            dead <= 1'b1;
        end
    end

    assign alive = ~dead;

    // steps taken, held at the top value
    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            step_count <= 8'd0;
        end else if (step && step_count != STEP_MAX) begin
            step_count <= step_count + 8'd1;
        end
    end

    // read mux and error decode
    always_comb begin
        apb_rsp = '0;
        apb_rsp.pready = 1'b1;
        case (apb_req.paddr)
            ADDR_CTRL: begin
                apb_rsp.prdata = {29'd0, dir_req, run};
            end
            ADDR_STATUS: begin
                apb_rsp.prdata = {16'd0, step_count, 7'd0, dead};
            end
            default: begin
                // unmapped, flag in the access phase only
                apb_rsp.pslverr = access;
            end
        endcase
    end

endmodule

// File: design/head_stepper.sv
`timescale 1ns/1ps

module head_stepper (
    input  logic                clock_10hz,
    input  logic                reset,
    input  logic                run,
    input  logic                alive,
    input  snake_pkg::heading_t dir_req,
    output snake_pkg::step_t    step,
    output logic                wall_hit
);

    import snake_pkg::*;

    node_t    head;
    heading_t heading;
    heading_t turn_heading;
    node_t    next_head;
    edge_t    next_edge;
    logic     legal;

    // up/down and left/right pairs differ in bit 0 only
    function automatic logic is_reverse(input heading_t a, input heading_t b);
        return (a ^ b) == 2'b01;
    endfunction

    // turn rule, a reverse request keeps the old heading
    always_comb begin
        if (is_reverse(dir_req, heading)) begin
            turn_heading = heading;
        end else begin
            turn_heading = dir_req;
        end
    end

    // next node, the edge it makes, and the wall check
    always_comb begin
        next_head = head;
        next_edge = '0;
        next_edge.valid = 1'b1;
        legal = 1'b0;
        case (turn_heading)
            DIR_RIGHT: begin
                // only from the left side of a digit
                legal = ~head.x[0] && (({1'b0, head.x} + 5'd1) < GRID_X);
                next_head.x = head.x + 4'd1;
                next_edge.pos.h.digit = head.x[3:1];
                next_edge.pos.h.level = head.y;
            end
            DIR_LEFT: begin
                legal = head.x[0];
                next_head.x = head.x - 4'd1;
                next_edge.pos.h.digit = head.x[3:1];
                next_edge.pos.h.level = head.y;
            end
            DIR_UP: begin
                legal = (head.y != 2'd0);
                next_head.y = head.y - 2'd1;
                next_edge.vertical = 1'b1;
                next_edge.pos.v.column = head.x;
                next_edge.pos.v.half = next_head.y[0];
            end
            default: begin
                legal = (({1'b0, head.y} + 3'd1) < GRID_Y);
                next_head.y = head.y + 2'd1;
                next_edge.vertical = 1'b1;
                next_edge.pos.v.column = head.x;
                next_edge.pos.v.half = head.y[0];
            end
        endcase
    end

    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            head <= START_NODE;
            heading <= DIR_RIGHT;
            step <= '0;
            wall_hit <= 1'b0;
        end else begin
            step.valid <= 1'b0;
            wall_hit <= 1'b0;
            if (run && alive) begin
                if (legal) begin
                    head <= next_head;
                    heading <= turn_heading;
                    step.valid <= 1'b1;
                    step.new_edge <= next_edge;
                end else begin
                    // head stays where it was
                    wall_hit <= 1'b1;
                end
            end
        end
    end

endmodule

// File: design/body_shift.sv
`timescale 1ns/1ps

module body_shift (
    input  logic                                      clock_10hz,
    input  logic                                      reset,
    input  snake_pkg::step_t                          step,
    output snake_pkg::edge_t [snake_pkg::BODY_LEN-1:0] body,
    output logic                                      self_hit
);

    import snake_pkg::*;

    logic hit_any;

    // compare against every stored entry before the shift
    always_comb begin
        hit_any = 1'b0;
        for (int i = 0; i < BODY_LEN; i++) begin
            if (body[i].valid && body[i] == step.new_edge) begin
                hit_any = 1'b1;
            end
        end
    end

    // entry 0 is the newest edge, the oldest falls off the top
    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            body <= '0;
            self_hit <= 1'b0;
        end else begin
            self_hit <= step.valid & hit_any;
            if (step.valid) begin
                // shift goes ahead even on a self hit
                body <= {body[BODY_LEN-2:0], step.new_edge};
            end
        end
    end

endmodule

// File: design/segment_map.sv
`timescale 1ns/1ps

module segment_map (
    input  logic                                      clock_10hz,
    input  logic                                      reset,
    input  snake_pkg::edge_t [snake_pkg::BODY_LEN-1:0] body,
    output logic [55:0]                               display
);

    import snake_pkg::*;

    logic [DIGITS*SEGS_PER_DIGIT-1:0] pattern;

    // or together the segment of each valid entry
    always_comb begin
        logic [2:0] digit;
        int         seg;
        pattern = '0;
        for (int i = 0; i < BODY_LEN; i++) begin
            digit = 3'd0;
            seg = -1;
            if (body[i].valid && body[i].vertical) begin
                digit = body[i].pos.v.column[3:1];
                if (body[i].pos.v.column[0]) begin
                    // right side of the digit
                    seg = body[i].pos.v.half ? SEG_C : SEG_B;
                end else begin
                    seg = body[i].pos.v.half ? SEG_E : SEG_F;
                end
            end else if (body[i].valid) begin
                digit = body[i].pos.h.digit;
                case (body[i].pos.h.level)
                    2'd0: seg = SEG_A;
                    2'd1: seg = SEG_G;
                    2'd2: seg = SEG_D;
                    default: seg = -1;
                endcase
            end
            if (seg >= 0) begin
                pattern[digit*SEGS_PER_DIGIT + seg] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            display <= '0;
        end else begin
            display <= pattern;
        end
    end

endmodule

// File: design/snake_top.sv
`timescale 1ns/1ps

module snake_top (
    input  logic                clock_10hz,
    input  logic                reset,
    input  snake_pkg::apb_req_t apb_req,
    output snake_pkg::apb_rsp_t apb_rsp,
    output logic [55:0]         display
);

    import snake_pkg::*;

    logic                   run;
    logic                   alive;
    heading_t               dir_req;
    step_t                  step;
    logic                   wall_hit;
    logic                   self_hit;
    hit_t                   hit;
    edge_t [BODY_LEN-1:0]   body;

    // both death events go to the dead latch
    assign hit = '{wall: wall_hit, self: self_hit};

    apb_ctrl_regs u_regs (
        .clock_10hz (clock_10hz),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .step       (step.valid),
        .hit        (hit),
        .run        (run),
        .dir_req    (dir_req),
        .alive      (alive)
    );

    // stage 1
    head_stepper u_stepper (
        .clock_10hz (clock_10hz),
        .reset      (reset),
        .run        (run),
        .alive      (alive),
        .dir_req    (dir_req),
        .step       (step),
        .wall_hit   (wall_hit)
    );

    // stage 2
    body_shift u_body (
        .clock_10hz (clock_10hz),
        .reset      (reset),
        .step       (step),
        .body       (body),
        .self_hit   (self_hit)
    );

    // stage 3
    segment_map u_segs (
        .clock_10hz (clock_10hz),
        .reset      (reset),
        .body       (body),
        .display    (display)
    );

endmodule

// File: verif/snake_tb.sv
`timescale 1ns/1ps

module snake_tb;

    import snake_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam int READY_LIMIT = 16;

    // one scenario, path letters are applied one per run cycle
    typedef struct packed {
        logic [63:0] path;
        logic [3:0]  run_cycles;
        logic [55:0] display;
        logic        dead;
        logic [7:0]  step_count;
    } scenario_t;

    logic        clock_10hz;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [55:0] display;

    scenario_t table_rows [NUM_ROWS];
    apb_rsp_t  last_rsp;
    int        row_count;

    snake_top UUT (
        .clock_10hz (clock_10hz),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .display    (display)
    );

    initial begin
        clock_10hz = 1'b0;
        forever begin
            #2 clock_10hz = ~clock_10hz;
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail at time %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) @(negedge clock_10hz);
    endtask

    task automatic add_row(input logic [63:0] path, input logic [3:0] cycles,
                           input logic [55:0] disp, input logic dead,
                           input logic [7:0] count);
        table_rows[row_count] = {path, cycles, disp, dead, count};
        row_count++;
    endtask

    // letters U D L R, the last letter repeats once the path runs out
    function automatic heading_t dir_at(input logic [63:0] path, input int idx);
        int         len;
        int         pick;
        logic [7:0] letter;
        len = 0;
        for (int i = 0; i < 8; i++) begin
            if (path[8*i +: 8] != 8'd0) begin
                len = i + 1;
            end
        end
        if (len == 0) begin
            return DIR_RIGHT;
        end
        pick = (idx < len) ? idx : len - 1;
        letter = path[8*(len-1-pick) +: 8];
        case (letter)
            "U": return DIR_UP;
            "D": return DIR_DOWN;
            "L": return DIR_LEFT;
            default: return DIR_RIGHT;
        endcase
    endfunction

    task automatic apply_reset();
        @(negedge clock_10hz);
        reset = 1'b0;
        apb_req = '0;
        repeat (2) @(negedge clock_10hz);
        reset = 1'b1;
    endtask

    // setup phase of one transfer
    task automatic start_transfer(input logic write, input logic [3:0] addr,
                                  input logic [31:0] data);
        @(negedge clock_10hz);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = data;
    endtask

    // response sampled mid cycle, returns once the access edge has passed
    task automatic wait_ready(input string what);
        int waited;
        waited = 0;
        #1;
        while (!apb_rsp.pready && waited < READY_LIMIT) begin
            @(negedge clock_10hz);
            #1;
            waited++;
        end
        if (!apb_rsp.pready) begin
            stop_on_error($sformatf("%s got no pready within %0d cycles", what, READY_LIMIT));
        end else begin
            last_rsp = apb_rsp;
            @(posedge clock_10hz);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        start_transfer(1'b1, addr, data);
        @(negedge clock_10hz);
        apb_req.penable = 1'b1;
        wait_ready("APB write");
        err = last_rsp.pslverr;
        @(negedge clock_10hz);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        start_transfer(1'b0, addr, 32'd0);
        @(negedge clock_10hz);
        apb_req.penable = 1'b1;
        wait_ready("APB read");
        data = last_rsp.prdata;
        err = last_rsp.pslverr;
        @(negedge clock_10hz);
        apb_req = '0;
    endtask

    // one control write lands per cycle, so step k uses path letter k
    task automatic run_steps(input logic [63:0] path, input int cycles);
        heading_t dir;
        dir = dir_at(path, 0);
        start_transfer(1'b1, ADDR_CTRL, {29'd0, dir, 1'b1});
        for (int k = 0; k <= cycles; k++) begin
            @(negedge clock_10hz);
            apb_req.penable = 1'b1;
            if (k < cycles) begin
                dir = dir_at(path, k);
                apb_req.pwdata = {29'd0, dir, 1'b1};
            end else begin
                // run drops, the last step still goes
                apb_req.pwdata = {29'd0, dir, 1'b0};
            end
            wait_ready("run write");
        end
        @(negedge clock_10hz);
        apb_req = '0;
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        scenario_t   row;
        reset = 1'b0;
        apb_req = '0;
        row_count = 0;

        // the snake never leaves digit 0, bits a to g from the lsb
        add_row("", 4'd0, 56'h00, 1'b0, 8'd0);
        add_row("R", 4'd1, 56'h01, 1'b0, 8'd1);
        add_row("RDDL", 4'd4, 56'h0f, 1'b0, 8'd4);
        // a drops out, then b
        add_row("RDDLUU", 4'd6, 56'h3c, 1'b0, 8'd6);
        // left and up are reverse requests here
        add_row("LDU", 4'd3, 56'h07, 1'b0, 8'd3);
        // right from x=1 into the gap
        add_row("R", 4'd3, 56'h01, 1'b1, 8'd1);
        // up from y=0 on the right side
        add_row("DDRU", 4'd7, 56'h1e, 1'b1, 8'd5);
        // closed loop, fifth step hits the stored a edge
        add_row("RDLUR", 4'd5, 56'h63, 1'b1, 8'd5);

        for (int r = 0; r < row_count; r++) begin
            row = table_rows[r];
            apply_reset();
            if (row.run_cycles == 0) begin
                wait_cycles(10);
            end else begin
                run_steps(row.path, row.run_cycles);
            end
            wait_cycles(4);
            apb_read(ADDR_STATUS, rdata, err);
            check_value("pslverr", err, 1'b0);
            check_value("dead", rdata[0], row.dead);
            check_value("step_count", rdata[15:8], row.step_count);
            check_value("display", display, row.display);
        end

        // unmapped address must not start the game
        apply_reset();
        apb_write(4'h8, {29'd0, DIR_DOWN, 1'b1}, err);
        check_value("pslverr", err, 1'b1);
        apb_read(4'h8, rdata, err);
        check_value("pslverr", err, 1'b1);
        wait_cycles(4);
        apb_read(ADDR_STATUS, rdata, err);
        check_value("pslverr", err, 1'b0);
        check_value("status", rdata, 32'd0);
        check_value("display", display, 56'd0);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: list.f
design/snake_pkg.sv
design/apb_ctrl_regs.sv
design/head_stepper.sv
design/body_shift.sv
design/segment_map.sv
design/snake_top.sv
verif/snake_tb.sv

// File: Bender.yml
package:
  name: snake_game

sources:
  - design/snake_pkg.sv
  - design/apb_ctrl_regs.sv
  - design/head_stepper.sv
  - design/body_shift.sv
  - design/segment_map.sv
  - design/snake_top.sv
  - target: simulation
    files:
      - verif/snake_tb.sv
